// ==== Makefile ====
# Verilator build and run of the ADC subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_adc_subsystem
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim.f ====
verilog/adc_pkg.sv
verilog/adc_capture.sv
verilog/spi_3wire_engine.sv
verilog/stream_merge.sv
verilog/adc_subsystem_top.sv
verification/tb_clock_gen.sv
verification/tb_adc_subsystem.sv

// ==== verification/tb_adc_subsystem.sv ====
/*
  Testbench for the ADC subsystem top level.
  Drives random sample beats and register commands on the falling clock
  edge, models the converter's SPI register file and a credit receiver,
  and checks the record stream against queues of expected samples and
  expected read data. Prints one line per test and a closing summary.
*/

`timescale 1ns/10ps

module tb_adc_subsystem;
  import adc_pkg::*;

  localparam int DECIM   = 2;
  localparam int CLK_DIV = 2;
  localparam int CREDITS = 4;
  localparam int N_CMDS  = 12;
  localparam int N_PAIRS = 120;
  localparam logic [12:0] ADDR_BASE = 13'h0140;
  // Four command tests and three sample tests, two beats per pair, margin of 4
  localparam int LIMIT = (4 * N_CMDS * 48 * CLK_DIV + 6 * N_PAIRS) * 4;
  // Longer than the three cycles from a low beat to its record with credits free
  localparam int SETTLE = 4;

  logic        clk;
  logic        rst;
  logic        capture_en;
  logic [7:0]  adc_data;
  logic        adc_frame;
  logic        adc_or;
  logic        cmd_valid;
  spi_op_e     cmd_op;
  logic [12:0] cmd_addr;
  logic [7:0]  cmd_wdata;
  logic        cmd_ready;
  logic        spi_csn;
  logic        spi_clk;
  logic        spi_sdio;
  logic        spi_sdio_oe;
  logic        spi_sdio_in;
  logic        credit;
  logic        out_valid;
  rec_kind_e   out_kind;
  logic [15:0] out_data;
  logic        out_flag;
  logic [15:0] drop_count;

  // Converter model and scoreboard state
  logic [7:0]  conv_regs [8192];
  logic [7:0]  exp_regs [8192];
  logic [23:0] frm_sh;
  int          bit_n;
  logic        conv_read;
  logic [7:0]  conv_rd;
  logic        sclk_prev;
  logic        csn_prev;
  logic [21:0] cmd_q [$];
  logic [7:0]  rd_q [$];
  logic [16:0] smp_q [$];
  int          errors;
  int          err_base;
  int          tests_run;
  int          cycles;
  int          pairs_done;
  int          produced;
  int          delivered;
  int          skipped;
  int          outstanding;
  int          hold_cnt;
  int          credit_mode;
  logic        withhold;
  logic        strict;

  tb_clock_gen #(.PERIOD(40.0)) u_clk (
    .clk_o (clk),
    .rst_o (rst)
  );

  adc_subsystem_top #(.DECIM(DECIM), .CLK_DIV(CLK_DIV), .CREDITS(CREDITS)) u_dut (
    .adc_clk_i     (clk),
    .rst_i         (rst),
    .capture_en_i  (capture_en),
    .adc_data_i    (adc_data),
    .adc_frame_i   (adc_frame),
    .adc_or_i      (adc_or),
    .cmd_valid_i   (cmd_valid),
    .cmd_op_i      (cmd_op),
    .cmd_addr_i    (cmd_addr),
    .cmd_wdata_i   (cmd_wdata),
    .cmd_ready_o   (cmd_ready),
    .spi_csn_o     (spi_csn),
    .spi_clk_o     (spi_clk),
    .spi_sdio_o    (spi_sdio),
    .spi_sdio_oe_o (spi_sdio_oe),
    .spi_sdio_i    (spi_sdio_in),
    .credit_i      (credit),
    .out_valid_o   (out_valid),
    .out_kind_o    (out_kind),
    .out_data_o    (out_data),
    .out_flag_o    (out_flag),
    .drop_count_o  (drop_count)
  );

  // Power-on contents of the converter's registers
  function automatic logic [7:0] reg_reset_value(input logic [12:0] addr);
    return addr[7:0] ^ {3'b000, addr[12:8]} ^ 8'h5A;
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAIL %0t ns %s: got %0h, expected %0h", $time, sig, got, exp);
    errors++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic end_test(input string name);
    $display("%-22s finished with %0d errors", name, errors - err_base);
    err_base = errors;
    tests_run++;
  endtask

  // **************************************************
  // Converter model on the SPI pins
  // **************************************************

  task automatic check_frame();
    logic [21:0] cmd;
    if (bit_n != 24) begin
      report_error("SPI frame did not have 24 clock pulses");
    end
    if (cmd_q.size() == 0) begin
      report_error("SPI frame seen with no command issued");
    end else begin
      cmd = cmd_q.pop_front();
      if (frm_sh[23:21] != {cmd[21], 2'b00}) begin
        report_mismatch("spi_sdio_o read and length bits", frm_sh[23:21], {cmd[21], 2'b00});
      end
      if (frm_sh[20:8] != cmd[20:8]) begin
        report_mismatch("spi_sdio_o address", frm_sh[20:8], cmd[20:8]);
      end
      if (!cmd[21]) begin
        if (frm_sh[7:0] != cmd[7:0]) begin
          report_mismatch("spi_sdio_o data", frm_sh[7:0], cmd[7:0]);
        end
        conv_regs[frm_sh[20:8]] = frm_sh[7:0];
      end
    end
    bit_n = 0;
  endtask

  // SCLK and CSN edges are seen half a cycle after the clock edge that made them
  always @(negedge clk) begin
    if (rst) begin
      bit_n       = 0;
      conv_read   = 1'b0;
      sclk_prev   = 1'b0;
      csn_prev    = 1'b1;
      spi_sdio_in = 1'b0;
    end else begin
      if (spi_clk && !sclk_prev && !spi_csn) begin
        if (spi_sdio_oe != (bit_n < 16 || !conv_read)) begin
          report_mismatch("spi_sdio_oe_o", spi_sdio_oe, bit_n < 16 || !conv_read);
        end
        if (bit_n == 0) begin
          conv_read = spi_sdio;
        end
        frm_sh = {frm_sh[22:0], spi_sdio};
        bit_n++;
        if (bit_n == 16) begin
          conv_rd = conv_regs[frm_sh[12:0]];
        end
      end
      if (spi_csn && !csn_prev) begin
        check_frame();
      end
      sclk_prev = spi_clk;
      csn_prev  = spi_csn;
      // Read data goes out MSB first for the last 8 rising edges
      if (!spi_csn && conv_read && bit_n >= 16 && bit_n < 24) begin
        spi_sdio_in = conv_rd[23 - bit_n];
      end else begin
        spi_sdio_in = 1'b0;
      end
    end
  end

  // **************************************************
  // Record monitor and credit receiver
  // **************************************************

  task automatic check_reg_record();
    logic [7:0] exp;
    if (rd_q.size() == 0) begin
      report_error("register record arrived with no read pending");
    end else begin
      exp = rd_q.pop_front();
      if (out_data != {8'h00, exp}) begin
        report_mismatch("out_data_o", out_data, {8'h00, exp});
      end
      if (out_flag) begin
        report_mismatch("out_flag_o", out_flag, 0);
      end
    end
  endtask

  task automatic check_sample_record();
    logic [16:0] got;
    got = {out_flag, out_data};
    if (strict && smp_q.size() > 0) begin
      if (smp_q[0] != got) begin
        report_mismatch("out_flag_o and out_data_o", got, smp_q[0]);
      end
      void'(smp_q.pop_front());
      delivered++;
    end else begin
      // Samples the DUT dropped are passed over
      while (smp_q.size() > 0 && smp_q[0] != got) begin
        void'(smp_q.pop_front());
        skipped++;
      end
      if (smp_q.size() == 0) begin
        report_error($sformatf("sample %0h is not in the expected stream", got));
      end else begin
        void'(smp_q.pop_front());
        delivered++;
      end
    end
  endtask

  always @(negedge clk) begin
    credit = 1'b0;
    if (!rst) begin
      if (out_valid) begin
        outstanding++;
        if (outstanding > CREDITS) begin
          report_error("record sent while no credit was left");
        end
        if (out_kind == REC_REG) begin
          check_reg_record();
        end else begin
          check_sample_record();
        end
      end
      if (credit_mode != 0 && hold_cnt == 0) begin
        withhold = !withhold;
        hold_cnt = withhold ? int'($urandom_range(60, 20)) : int'($urandom_range(20, 5));
      end
      if (hold_cnt > 0) begin
        hold_cnt--;
      end
      if (outstanding > 0 && (credit_mode == 0 || (!withhold && $urandom_range(1, 0) == 1))) begin
        credit = 1'b1;
        outstanding--;
      end
    end
  end

  // **************************************************
  // Stimulus
  // **************************************************

  task automatic drive_pairs(input int n);
    logic [7:0] hi;
    logic [7:0] lo;
    logic       or_h;
    logic       or_l;
    repeat (n) begin
      hi   = 8'($urandom);
      lo   = 8'($urandom);
      or_h = ($urandom_range(7, 0) == 0);
      or_l = ($urandom_range(7, 0) == 0);
      @(negedge clk);
      adc_frame = 1'b1;
      adc_data  = hi;
      adc_or    = or_h;
      @(negedge clk);
      adc_frame = 1'b0;
      adc_data  = lo;
      adc_or    = or_l;
      pairs_done++;
      if (pairs_done % DECIM == 0) begin
        smp_q.push_back({or_h | or_l, 16'(hi) * 16'd256 + 16'(lo)});
        produced++;
      end
      repeat ($urandom_range(2, 0)) @(negedge clk);
    end
  endtask

  task automatic issue_cmd(input spi_op_e op);
    logic [12:0] addr;
    logic [7:0]  data;
    addr = ADDR_BASE + 13'($urandom_range(7, 0));
    data = 8'($urandom);
    @(negedge clk);
    while (!cmd_ready) @(negedge clk);
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_addr  = addr;
    cmd_wdata = data;
    cmd_q.push_back({op, addr, data});
    if (op == SPI_READ) begin
      rd_q.push_back(exp_regs[addr]);
    end else begin
      exp_regs[addr] = data;
    end
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  // Mode 0 writes, mode 1 reads, mode 2 a random mix
  task automatic run_cmds(input int n, input int mode);
    repeat (n) begin
      if (mode == 2) begin
        issue_cmd(spi_op_e'($urandom_range(1, 0)));
      end else begin
        issue_cmd(mode == 1 ? SPI_READ : SPI_WRITE);
      end
    end
  endtask

  // Waits until every command and read is done and the record stream has
  // stayed quiet with all credits back for longer than a sample's latency
  task automatic drain();
    int quiet;
    credit_mode = 0;
    quiet       = 0;
    while (quiet < SETTLE) begin
      @(negedge clk);
      if (rd_q.size() != 0 || cmd_q.size() != 0 || !cmd_ready ||
          outstanding != 0 || out_valid) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
    skipped += smp_q.size();
    smp_q.delete();
  endtask

  task automatic check_drops();
    if (int'(drop_count) != skipped) begin
      report_mismatch("drop_count_o", drop_count, skipped);
    end
  endtask

  initial begin
    capture_en  = 1'b0;
    adc_data    = 8'h00;
    adc_frame   = 1'b0;
    adc_or      = 1'b0;
    cmd_valid   = 1'b0;
    cmd_op      = SPI_WRITE;
    cmd_addr    = '0;
    cmd_wdata   = '0;
    spi_sdio_in = 1'b0;
    credit      = 1'b0;
    errors      = 0;
    err_base    = 0;
    tests_run   = 0;
    pairs_done  = 0;
    produced    = 0;
    delivered   = 0;
    skipped     = 0;
    outstanding = 0;
    hold_cnt    = 0;
    credit_mode = 0;
    withhold    = 1'b0;
    strict      = 1'b1;
    void'($urandom(32'h6988));
    for (int a = 0; a < 8192; a++) begin
      conv_regs[a] = reg_reset_value(13'(a));
      exp_regs[a]  = reg_reset_value(13'(a));
    end
    wait (!rst);
    @(negedge clk);

    if (out_valid !== 1'b0) report_mismatch("out_valid_o", out_valid, 0);
    if (spi_sdio_oe !== 1'b0) report_mismatch("spi_sdio_oe_o", spi_sdio_oe, 0);
    if (spi_clk !== 1'b0) report_mismatch("spi_clk_o", spi_clk, 0);
    if (spi_csn !== 1'b1) report_mismatch("spi_csn_o", spi_csn, 1);
    if (cmd_ready !== 1'b1) report_mismatch("cmd_ready_o", cmd_ready, 1);
    if (drop_count !== 16'h0000) report_mismatch("drop_count_o", drop_count, 0);
    end_test("reset values");
    capture_en = 1'b1;

    run_cmds(N_CMDS, 0);
    drain();
    end_test("register writes");

    run_cmds(N_CMDS, 1);
    drain();
    end_test("register reads");

    drive_pairs(N_PAIRS);
    drain();
    if (drop_count != 16'h0000) report_mismatch("drop_count_o", drop_count, 0);
    check_drops();
    end_test("samples, ample credits");

    strict      = 1'b0;
    credit_mode = 1;
    fork
      drive_pairs(N_PAIRS);
      run_cmds(N_CMDS, 1);
    join
    drain();
    check_drops();
    end_test("back-pressure");

    strict = 1'b1;
    fork
      drive_pairs(N_PAIRS);
      run_cmds(N_CMDS, 2);
    join
    drain();
    check_drops();
    end_test("mixed traffic");

    $display("%0d tests, %0d samples delivered, %0d dropped, %0d errors",
             tests_run, delivered, skipped, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, records or commands never completed", LIMIT);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== verification/tb_clock_gen.sv ====
/*
  Clock and reset source for the ADC subsystem testbench.
  Free-running clock of PERIOD ns, reset held high over two rising edges
  and released on the following falling edge.
*/

`timescale 1ns/10ps

module tb_clock_gen #(
  parameter real PERIOD = 40.0
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2.0) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// ==== verilog/adc_capture.sv ====
/*
  Sample capture from the converter's 8-bit data bus.
  A beat with the frame bit set carries the high byte, the following beat
  the low byte. The assembled sample is marked one cycle after the low
  beat, and only every DECIM-th sample is passed on as a one-cycle pulse.
*/

`timescale 1ns/10ps

module adc_capture #(
  parameter int DECIM = 2
) (
  input  logic                          adc_clk_i,
  input  logic                          rst_i,
  input  logic                          capture_en_i,
  input  logic [7:0]                    adc_data_i,
  input  logic                          adc_frame_i,
  input  logic                          adc_or_i,
  output logic                          sample_valid_o,
  output logic [adc_pkg::SAMPLE_W-1:0]  sample_data_o,
  output logic                          sample_or_o
);

  localparam int CNT_W = (DECIM > 1) ? $clog2(DECIM) : 1;

  logic [7:0]       hi_byte_q;
  logic             hi_or_q;
  logic             hi_valid_q;
  logic [CNT_W-1:0] dec_cnt_q;
  logic             lo_beat;

  // A low beat completes the sample only if a high beat came before it
  assign lo_beat = capture_en_i && !adc_frame_i && hi_valid_q;

  always_ff @(posedge adc_clk_i) begin
    if (rst_i) begin
      hi_valid_q     <= 1'b0;
      dec_cnt_q      <= '0;
      sample_valid_o <= 1'b0;
    end else begin
      sample_valid_o <= 1'b0;
      if (capture_en_i && adc_frame_i) begin
        hi_valid_q <= 1'b1;
      end else if (lo_beat) begin
        hi_valid_q <= 1'b0;
        // Forward the DECIM-th completed sample and restart the count
        if (dec_cnt_q == CNT_W'(DECIM - 1)) begin
          dec_cnt_q      <= '0;
          sample_valid_o <= 1'b1;
        end else begin
          dec_cnt_q <= dec_cnt_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge adc_clk_i) begin
    if (capture_en_i && adc_frame_i) begin
      hi_byte_q <= adc_data_i;
      hi_or_q   <= adc_or_i;
    end
    if (lo_beat) begin
      sample_data_o <= {hi_byte_q, adc_data_i};
      sample_or_o   <= hi_or_q | adc_or_i;
    end
  end

  // The converter never marks two high beats back to back
  a_frame_spacing : assert property (
    @(posedge adc_clk_i) disable iff (rst_i) adc_frame_i |=> !adc_frame_i
  );

endmodule

// ==== verilog/adc_pkg.sv ====
/*
  Shared definitions for the ADC capture and register access subsystem.
  Holds the widths fixed by the converter's SPI frame and sample format,
  and the enums for SPI operations, SPI engine states and record kinds.
  Modules pull these in with a wildcard import in their body.
*/

package adc_pkg;

  // **************************************************
  // Protocol widths
  // **************************************************

  // Register address field of the 3-wire SPI frame
  localparam int REG_ADDR_W = 13;

  // Register data field of the 3-wire SPI frame
  localparam int REG_DATA_W = 8;

  // One sample is assembled from two 8-bit beats
  localparam int SAMPLE_W = 16;

  // **************************************************
  // Enums
  // **************************************************

  typedef enum logic {
    SPI_WRITE = 1'b0,
    SPI_READ  = 1'b1
  } spi_op_e;

  typedef enum logic [2:0] {
    SPI_IDLE,
    SPI_SHIFT_OUT,
    SPI_SHIFT_IN,
    SPI_DONE,
    SPI_HOLD
  } spi_state_e;

  typedef enum logic {
    REC_SAMPLE = 1'b0,
    REC_REG    = 1'b1
  } rec_kind_e;

endpackage

// ==== verilog/adc_subsystem_top.sv ====
/*
  Top level of the ADC board logic, all on adc_clk_i.
  Capture and the SPI engine run side by side and the stream merger
  combines their results into one credit-controlled record stream.
  The SPI data line is split into in, out and output-enable.
*/

`timescale 1ns/10ps

module adc_subsystem_top #(
  parameter int DECIM   = 2,
  parameter int CLK_DIV = 2,
  parameter int CREDITS = 4
) (
  input  logic                            adc_clk_i,
  input  logic                            rst_i,
  input  logic                            capture_en_i,
  input  logic [7:0]                      adc_data_i,
  input  logic                            adc_frame_i,
  input  logic                            adc_or_i,
  input  logic                            cmd_valid_i,
  input  adc_pkg::spi_op_e                cmd_op_i,
  input  logic [adc_pkg::REG_ADDR_W-1:0]  cmd_addr_i,
  input  logic [adc_pkg::REG_DATA_W-1:0]  cmd_wdata_i,
  output logic                            cmd_ready_o,
  output logic                            spi_csn_o,
  output logic                            spi_clk_o,
  output logic                            spi_sdio_o,
  output logic                            spi_sdio_oe_o,
  input  logic                            spi_sdio_i,
  input  logic                            credit_i,
  output logic                            out_valid_o,
  output adc_pkg::rec_kind_e              out_kind_o,
  output logic [adc_pkg::SAMPLE_W-1:0]    out_data_o,
  output logic                            out_flag_o,
  output logic [15:0]                     drop_count_o
);
  import adc_pkg::*;

  logic                  sample_valid;
  logic [SAMPLE_W-1:0]   sample_data;
  logic                  sample_or;
  logic                  resp_valid;
  logic [REG_DATA_W-1:0] resp_data;
  logic                  resp_ready;

  adc_capture #(.DECIM(DECIM)) u_capture (
    .adc_clk_i      (adc_clk_i),
    .rst_i          (rst_i),
    .capture_en_i   (capture_en_i),
    .adc_data_i     (adc_data_i),
    .adc_frame_i    (adc_frame_i),
    .adc_or_i       (adc_or_i),
    .sample_valid_o (sample_valid),
    .sample_data_o  (sample_data),
    .sample_or_o    (sample_or)
  );

  spi_3wire_engine #(.CLK_DIV(CLK_DIV)) u_spi (
    .adc_clk_i     (adc_clk_i),
    .rst_i         (rst_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_op_i      (cmd_op_i),
    .cmd_addr_i    (cmd_addr_i),
    .cmd_wdata_i   (cmd_wdata_i),
    .cmd_ready_o   (cmd_ready_o),
    .spi_csn_o     (spi_csn_o),
    .spi_clk_o     (spi_clk_o),
    .spi_sdio_o    (spi_sdio_o),
    .spi_sdio_oe_o (spi_sdio_oe_o),
    .spi_sdio_i    (spi_sdio_i),
    .resp_valid_o  (resp_valid),
    .resp_data_o   (resp_data),
    .resp_ready_i  (resp_ready)
  );

  stream_merge #(.CREDITS(CREDITS)) u_merge (
    .adc_clk_i      (adc_clk_i),
    .rst_i          (rst_i),
    .sample_valid_i (sample_valid),
    .sample_data_i  (sample_data),
    .sample_or_i    (sample_or),
    .resp_valid_i   (resp_valid),
    .resp_data_i    (resp_data),
    .resp_ready_o   (resp_ready),
    .credit_i       (credit_i),
    .out_valid_o    (out_valid_o),
    .out_kind_o     (out_kind_o),
    .out_data_o     (out_data_o),
    .out_flag_o     (out_flag_o),
    .drop_count_o   (drop_count_o)
  );

endmodule

// ==== verilog/spi_3wire_engine.sv ====
/*
  Register access engine for the converter's 3-wire SPI bus.
  Takes one write or read command at a time and shifts a 24-bit frame
  MSB first, SCLK half period set by CLK_DIV. For a read the data line is
  released after the address and 8 bits are shifted in, then held as the
  response until the stream merger accepts it.
*/

`timescale 1ns/10ps

module spi_3wire_engine #(
  parameter int CLK_DIV = 2
) (
  input  logic                            adc_clk_i,
  input  logic                            rst_i,
  input  logic                            cmd_valid_i,
  input  adc_pkg::spi_op_e                cmd_op_i,
  input  logic [adc_pkg::REG_ADDR_W-1:0]  cmd_addr_i,
  input  logic [adc_pkg::REG_DATA_W-1:0]  cmd_wdata_i,
  output logic                            cmd_ready_o,
  output logic                            spi_csn_o,
  output logic                            spi_clk_o,
  output logic                            spi_sdio_o,
  output logic                            spi_sdio_oe_o,
  input  logic                            spi_sdio_i,
  output logic                            resp_valid_o,
  output logic [adc_pkg::REG_DATA_W-1:0]  resp_data_o,
  input  logic                            resp_ready_i
);
  import adc_pkg::*;

  localparam int FRAME_W = 3 + REG_ADDR_W + REG_DATA_W;
  localparam int BIT_W   = $clog2(FRAME_W);
  localparam int DIV_W   = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  spi_state_e            state_q;
  logic [DIV_W-1:0]      div_cnt_q;
  logic [BIT_W-1:0]      bit_cnt_q;
  logic                  is_read_q;
  logic [FRAME_W-1:0]    tx_q;
  logic [REG_DATA_W-1:0] rx_q;
  logic                  cmd_take;
  logic                  shifting;
  logic                  half_tick;
  logic                  sclk_rise;
  logic                  sclk_fall;

  assign cmd_ready_o  = (state_q == SPI_IDLE);
  assign cmd_take     = cmd_valid_i && cmd_ready_o;
  assign shifting     = (state_q == SPI_SHIFT_OUT) || (state_q == SPI_SHIFT_IN);
  assign half_tick    = shifting && (div_cnt_q == DIV_W'(CLK_DIV - 1));
  assign sclk_rise    = half_tick && !spi_clk_o;
  assign sclk_fall    = half_tick && spi_clk_o;
  assign spi_sdio_o   = tx_q[FRAME_W-1];
  assign resp_valid_o = (state_q == SPI_HOLD);
  assign resp_data_o  = rx_q;

  // **************************************************
  // Frame sequencing
  // **************************************************

  always_ff @(posedge adc_clk_i) begin
    if (rst_i) begin
      state_q       <= SPI_IDLE;
      div_cnt_q     <= '0;
      bit_cnt_q     <= '0;
      is_read_q     <= 1'b0;
      spi_csn_o     <= 1'b1;
      spi_clk_o     <= 1'b0;
      spi_sdio_oe_o <= 1'b0;
    end else begin
      case (state_q)
        SPI_IDLE: begin
          if (cmd_valid_i) begin
            state_q       <= SPI_SHIFT_OUT;
            is_read_q     <= (cmd_op_i == SPI_READ);
            bit_cnt_q     <= BIT_W'(FRAME_W - 1);
            div_cnt_q     <= '0;
            spi_csn_o     <= 1'b0;
            spi_sdio_oe_o <= 1'b1;
          end
        end
        SPI_SHIFT_OUT, SPI_SHIFT_IN: begin
          div_cnt_q <= half_tick ? '0 : div_cnt_q + 1'b1;
          if (half_tick) begin
            spi_clk_o <= !spi_clk_o;
          end
          // Each falling edge closes one bit period
          if (sclk_fall) begin
            if (bit_cnt_q == '0) begin
              state_q       <= SPI_DONE;
              spi_csn_o     <= 1'b1;
              spi_sdio_oe_o <= 1'b0;
            end else begin
              bit_cnt_q <= bit_cnt_q - 1'b1;
              // Turn the line around once the address LSB is out
              if (is_read_q && bit_cnt_q == BIT_W'(REG_DATA_W)) begin
                state_q       <= SPI_SHIFT_IN;
                spi_sdio_oe_o <= 1'b0;
              end
            end
          end
        end
        SPI_DONE: state_q <= is_read_q ? SPI_HOLD : SPI_IDLE;
        SPI_HOLD: begin
          if (resp_ready_i) begin
            state_q <= SPI_IDLE;
          end
        end
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  // Read bit, two zero word-length bits, address, then data
  always_ff @(posedge adc_clk_i) begin
    if (cmd_take) begin
      tx_q <= {cmd_op_i == SPI_READ, 2'b00, cmd_addr_i,
               (cmd_op_i == SPI_READ) ? '0 : cmd_wdata_i};
    end else if (sclk_fall) begin
      tx_q <= {tx_q[FRAME_W-2:0], 1'b0};
    end
    if (sclk_rise && state_q == SPI_SHIFT_IN) begin
      rx_q <= {rx_q[REG_DATA_W-2:0], spi_sdio_i};
    end
  end

  a_oe_inside_frame : assert property (
    @(posedge adc_clk_i) disable iff (rst_i) spi_csn_o |-> !spi_sdio_oe_o
  );

  a_resp_stable : assert property (
    @(posedge adc_clk_i) disable iff (rst_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o)
  );

endmodule

// ==== verilog/stream_merge.sv ====
/*
  Merges captured samples and register read responses into one record
  stream. Each source has a one-entry slot; responses win over samples.
  A record is only sent while credits remain, and each returned credit
  pulse allows one more. Samples that find their slot full are counted.
*/

`timescale 1ns/10ps

module stream_merge #(
  parameter int CREDITS = 4
) (
  input  logic                            adc_clk_i,
  input  logic                            rst_i,
  input  logic                            sample_valid_i,
  input  logic [adc_pkg::SAMPLE_W-1:0]    sample_data_i,
  input  logic                            sample_or_i,
  input  logic                            resp_valid_i,
  input  logic [adc_pkg::REG_DATA_W-1:0]  resp_data_i,
  output logic                            resp_ready_o,
  input  logic                            credit_i,
  output logic                            out_valid_o,
  output adc_pkg::rec_kind_e              out_kind_o,
  output logic [adc_pkg::SAMPLE_W-1:0]    out_data_o,
  output logic                            out_flag_o,
  output logic [15:0]                     drop_count_o
);
  import adc_pkg::*;

  // One spare code so a surplus credit return is visible
  localparam int CNT_W = $clog2(CREDITS + 2);

  logic                  smp_vld_q;
  logic [SAMPLE_W-1:0]   smp_data_q;
  logic                  smp_or_q;
  logic                  rsp_vld_q;
  logic [REG_DATA_W-1:0] rsp_data_q;
  logic [CNT_W-1:0]      credit_q;
  logic                  send_rsp;
  logic                  send_smp;
  logic                  take_smp;
  logic                  take_rsp;

  assign resp_ready_o = !rsp_vld_q;
  assign send_rsp     = (credit_q != '0) && rsp_vld_q;
  assign send_smp     = (credit_q != '0) && !rsp_vld_q && smp_vld_q;
  // The sample slot can refill in the cycle it drains
  assign take_smp     = sample_valid_i && (!smp_vld_q || send_smp);
  assign take_rsp     = resp_valid_i && resp_ready_o;

  always_ff @(posedge adc_clk_i) begin
    if (rst_i) begin
      smp_vld_q    <= 1'b0;
      rsp_vld_q    <= 1'b0;
      credit_q     <= CNT_W'(CREDITS);
      out_valid_o  <= 1'b0;
      drop_count_o <= '0;
    end else begin
      out_valid_o <= send_rsp || send_smp;
      credit_q    <= credit_q - CNT_W'(send_rsp || send_smp) + CNT_W'(credit_i);
      if (take_smp) begin
        smp_vld_q <= 1'b1;
      end else if (send_smp) begin
        smp_vld_q <= 1'b0;
      end
      if (take_rsp) begin
        rsp_vld_q <= 1'b1;
      end else if (send_rsp) begin
        rsp_vld_q <= 1'b0;
      end
      if (sample_valid_i && !take_smp && drop_count_o != '1) begin
        drop_count_o <= drop_count_o + 1'b1;
      end
    end
  end

  always_ff @(posedge adc_clk_i) begin
    if (take_smp) begin
      smp_data_q <= sample_data_i;
      smp_or_q   <= sample_or_i;
    end
    if (take_rsp) begin
      rsp_data_q <= resp_data_i;
    end
    if (send_rsp) begin
      out_kind_o <= REC_REG;
      out_data_o <= SAMPLE_W'(rsp_data_q);
      out_flag_o <= 1'b0;
    end else if (send_smp) begin
      out_kind_o <= REC_SAMPLE;
      out_data_o <= smp_data_q;
      out_flag_o <= smp_or_q;
    end
  end

  a_credit_bound : assert property (
    @(posedge adc_clk_i) disable iff (rst_i) credit_q <= CNT_W'(CREDITS)
  );

endmodule
